// ==== include/rob_defines.svh ====
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// index bits of the reorder buffer, 64 entries
`define ROB_WIDTH 6

// set to 1'b0 to drop the concurrent assertions
`define ROB_ASSERT_ON 1'b1

`endif

// ==== hw/rob_pkg.sv ====
`include "rob_defines.svh"

package rob_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int ROB_WIDTH  = `ROB_WIDTH;
    localparam int ROB_DEPTH  = 1 << ROB_WIDTH;
    localparam int AREG_WIDTH = 5;
    localparam int WORD_WIDTH = 32;

    // enables the assertion blocks in the stages
    localparam bit ROB_ASSERT_ON = `ROB_ASSERT_ON;

    typedef logic [ROB_WIDTH-1:0]  rob_id_t;
    typedef logic [ROB_WIDTH:0]    rob_cnt_t;
    typedef logic [AREG_WIDTH-1:0] areg_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    //////////////////////////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////////////////////////

    // one dispatch slot
    typedef struct packed {
        logic  valid;
        areg_t areg;
        logic  w_reg;
        word_t pc;
    } dispatch_req_t;

    // instruction info kept per entry
    typedef struct packed {
        areg_t areg;
        logic  w_reg;
        word_t pc;
    } rob_inst_entry_t;

    // one result bus
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        word_t   data;
        logic    exc;
    } cdb_t;

    typedef struct packed {
        word_t data;
        logic  exc;
    } rob_data_entry_t;

    // view of one of the two oldest entries
    typedef struct packed {
        logic  complete;
        areg_t areg;
        logic  w_reg;
        word_t pc;
        word_t data;
        logic  exc;
    } rob_head_t;

    // one retired instruction
    typedef struct packed {
        logic  valid;
        areg_t areg;
        logic  w_reg;
        word_t pc;
        word_t data;
        logic  exc;
    } commit_t;

endpackage

// ==== hw/rob_bank_ram.sv ====
`timescale 1ns/1ns

module rob_bank_ram #(
    parameter int DATA_WIDTH = 1,
    parameter int DEPTH      = 64,
    parameter int R_PORTS    = 2,
    parameter int W_PORTS    = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n_i,
    input  logic                                      clear_i,

    input  logic [R_PORTS-1:0][$clog2(DEPTH)-1:0]     raddr_i,
    output logic [R_PORTS-1:0][DATA_WIDTH-1:0]        rdata_o,

    input  logic [W_PORTS-1:0][$clog2(DEPTH)-1:0]     waddr_i,
    input  logic [W_PORTS-1:0]                        we_i,
    input  logic [W_PORTS-1:0][DATA_WIDTH-1:0]        wdata_i
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    // later ports overwrite earlier ones on the same address
    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            for (int e = 0; e < DEPTH; e++) begin
                mem[e] <= '0;
            end
        end else begin
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    mem[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side, combinational
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    if (rob_pkg::ROB_ASSERT_ON) begin : g_assert
        for (genvar i = 0; i < W_PORTS; i++) begin : g_port
            for (genvar j = i + 1; j < W_PORTS; j++) begin : g_other
                // a bank conflict would silently drop the older write
                a_no_write_collision: assert property (
                    @(posedge clk) disable iff (!rst_n_i)
                    !(we_i[i] && we_i[j] && (waddr_i[i] == waddr_i[j]))
                );
            end
        end
    end

endmodule

// ==== hw/rob_alloc.sv ====
`timescale 1ns/1ns

module rob_alloc (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,

    input  rob_pkg::dispatch_req_t [1:0]     dispatch_i,
    input  logic [1:0]                       commit_cnt_i,
    output logic                             dispatch_ready_o,
    output rob_pkg::rob_id_t [1:0]           dispatch_id_o,

    output logic [1:0]                       alloc_we_o,
    output rob_pkg::rob_id_t [1:0]           alloc_id_o,
    output rob_pkg::rob_inst_entry_t [1:0]   alloc_entry_o
);

    rob_pkg::rob_id_t  alloc_ptr_q;
    rob_pkg::rob_cnt_t rob_cnt_q;
    rob_pkg::rob_cnt_t rob_cnt_d;
    rob_pkg::rob_cnt_t n_alloc;
    logic [1:0]        accept;

    // room for a full pair
    assign dispatch_ready_o = (rob_cnt_q <= rob_pkg::rob_cnt_t'(rob_pkg::ROB_DEPTH - 2));

    // slot 1 only rides along with slot 0
    assign accept[0] = dispatch_i[0].valid & dispatch_ready_o;
    assign accept[1] = dispatch_i[1].valid & dispatch_i[0].valid & dispatch_ready_o;

    assign n_alloc   = rob_pkg::rob_cnt_t'(accept[0]) + rob_pkg::rob_cnt_t'(accept[1]);
    assign rob_cnt_d = rob_cnt_q + n_alloc - rob_pkg::rob_cnt_t'(commit_cnt_i);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            alloc_ptr_q <= '0;
            rob_cnt_q   <= '0;
        end else begin
            alloc_ptr_q <= alloc_ptr_q + rob_pkg::rob_id_t'(n_alloc);
            rob_cnt_q   <= rob_cnt_d;
        end
    end

    // indices and table writes for the pair
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dispatch_id_o[i]       = alloc_ptr_q + rob_pkg::rob_id_t'(i);
            alloc_id_o[i]          = dispatch_id_o[i];
            alloc_entry_o[i].areg  = dispatch_i[i].areg;
            alloc_entry_o[i].w_reg = dispatch_i[i].w_reg;
            alloc_entry_o[i].pc    = dispatch_i[i].pc;
        end
        alloc_we_o = accept;
    end

    if (rob_pkg::ROB_ASSERT_ON) begin : g_assert
        a_cnt_bound: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            rob_cnt_q <= rob_pkg::rob_cnt_t'(rob_pkg::ROB_DEPTH)
        );
    end

endmodule

// ==== hw/rob.sv ====
`timescale 1ns/1ns

module rob (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,

    input  logic [1:0]                       alloc_we_i,
    input  rob_pkg::rob_id_t [1:0]           alloc_id_i,
    input  rob_pkg::rob_inst_entry_t [1:0]   alloc_entry_i,

    input  rob_pkg::cdb_t [1:0]              cdb_i,

    input  logic [1:0]                       commit_req_i,
    output rob_pkg::rob_head_t [1:0]         head_o,
    output logic [1:0]                       commit_cnt_o
);

    rob_pkg::rob_id_t  commit_ptr_q;
    rob_pkg::rob_cnt_t rob_cnt_q;
    rob_pkg::rob_id_t [1:0] head_id;

    rob_pkg::rob_id_t [1:0]         cdb_id;
    logic [1:0]                     cdb_we;
    rob_pkg::rob_data_entry_t [1:0] cdb_entry;

    rob_pkg::rob_inst_entry_t [1:0] head_inst;
    rob_pkg::rob_data_entry_t [1:0] head_data;

    // toggle reads, [1:0] at the head, [3:2] at the other side's write ports
    logic [3:0] dtog_rd;
    logic [3:0] ctog_rd;

    //////////////////////////////////////////////////////////////////////
    // commit pointer and occupancy
    //////////////////////////////////////////////////////////////////////
    assign commit_cnt_o = 2'(commit_req_i[0]) + 2'(commit_req_i[1]);
    assign head_id[0]   = commit_ptr_q;
    assign head_id[1]   = commit_ptr_q + rob_pkg::rob_id_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            commit_ptr_q <= '0;
            rob_cnt_q    <= '0;
        end else begin
            commit_ptr_q <= commit_ptr_q + rob_pkg::rob_id_t'(commit_cnt_o);
            rob_cnt_q    <= rob_cnt_q
                          + rob_pkg::rob_cnt_t'(alloc_we_i[0])
                          + rob_pkg::rob_cnt_t'(alloc_we_i[1])
                          - rob_pkg::rob_cnt_t'(commit_cnt_o);
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cdb_id[i]         = cdb_i[i].rob_id;
            cdb_we[i]         = cdb_i[i].valid;
            cdb_entry[i].data = cdb_i[i].data;
            cdb_entry[i].exc  = cdb_i[i].exc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry tables
    //////////////////////////////////////////////////////////////////////
    rob_bank_ram #(
        .DATA_WIDTH ($bits(rob_pkg::rob_inst_entry_t)),
        .DEPTH      (rob_pkg::ROB_DEPTH),
        .R_PORTS    (2),
        .W_PORTS    (2)
    ) inst_table (
        .clk,
        .rst_n_i,
        .clear_i    (1'b0),
        .raddr_i    (head_id),
        .rdata_o    (head_inst),
        .waddr_i    (alloc_id_i),
        .we_i       (alloc_we_i),
        .wdata_i    (alloc_entry_i)
    );

    rob_bank_ram #(
        .DATA_WIDTH ($bits(rob_pkg::rob_data_entry_t)),
        .DEPTH      (rob_pkg::ROB_DEPTH),
        .R_PORTS    (2),
        .W_PORTS    (2)
    ) data_table (
        .clk,
        .rst_n_i,
        .clear_i    (1'b0),
        .raddr_i    (head_id),
        .rdata_o    (head_data),
        .waddr_i    (cdb_id),
        .we_i       (cdb_we),
        .wdata_i    (cdb_entry)
    );

    //////////////////////////////////////////////////////////////////////
    // completion toggles
    //////////////////////////////////////////////////////////////////////

    // dispatch copies the cdb bit, entry reads incomplete
    rob_bank_ram #(
        .DATA_WIDTH (1),
        .DEPTH      (rob_pkg::ROB_DEPTH),
        .R_PORTS    (4),
        .W_PORTS    (2)
    ) dispatch_toggle (
        .clk,
        .rst_n_i,
        .clear_i    (flush_i),
        .raddr_i    ({cdb_id, head_id}),
        .rdata_o    (dtog_rd),
        .waddr_i    (alloc_id_i),
        .we_i       (alloc_we_i),
        .wdata_i    (ctog_rd[3:2])
    );

    // write-back inverts the dispatch bit, entry reads complete
    rob_bank_ram #(
        .DATA_WIDTH (1),
        .DEPTH      (rob_pkg::ROB_DEPTH),
        .R_PORTS    (4),
        .W_PORTS    (2)
    ) cdb_toggle (
        .clk,
        .rst_n_i,
        .clear_i    (flush_i),
        .raddr_i    ({alloc_id_i, head_id}),
        .rdata_o    (ctog_rd),
        .waddr_i    (cdb_id),
        .we_i       (cdb_we),
        .wdata_i    (~dtog_rd[3:2])
    );

    // head view, gated by how many entries are live
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            head_o[i].complete = (dtog_rd[i] ^ ctog_rd[i])
                               & (rob_cnt_q > rob_pkg::rob_cnt_t'(i));
            head_o[i].areg     = head_inst[i].areg;
            head_o[i].w_reg    = head_inst[i].w_reg;
            head_o[i].pc       = head_inst[i].pc;
            head_o[i].data     = head_data[i].data;
            head_o[i].exc      = head_data[i].exc;
        end
    end

    if (rob_pkg::ROB_ASSERT_ON) begin : g_assert
        a_commit_complete: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            (commit_req_i & ~{head_o[1].complete, head_o[0].complete}) == 2'b00
        );
    end

endmodule

// ==== hw/rob_commit.sv ====
`timescale 1ns/1ns

module rob_commit (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  rob_pkg::rob_head_t [1:0]     head_i,
    input  logic                         commit_ready_i,
    output logic [1:0]                   commit_req_o,

    output rob_pkg::commit_t [1:0]       commit_o,
    output logic                         flush_o,

    input  rob_pkg::areg_t               arf_raddr_i,
    output rob_pkg::word_t               arf_rdata_o
);

    logic [1:0]             retire;
    logic [1:0]             arf_we;
    logic                   flush_q;
    rob_pkg::commit_t [1:0] commit_q;

    // architectural register file
    rob_pkg::word_t arf [2**rob_pkg::AREG_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // retirement rule
    //////////////////////////////////////////////////////////////////////

    // nothing retires while the flush is going out
    always_comb begin
        retire[0] = head_i[0].complete & commit_ready_i & ~flush_q;
        retire[1] = retire[0] & head_i[1].complete & ~head_i[0].exc;
        for (int i = 0; i < 2; i++) begin
            arf_we[i] = retire[i] & head_i[i].w_reg & ~head_i[i].exc;
        end
    end

    assign commit_req_o = retire;

    //////////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////////

    // slot 1 is younger, so it wins on the same register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < 2**rob_pkg::AREG_WIDTH; r++) begin
                arf[r] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (arf_we[i]) begin
                    arf[head_i[i].areg] <= head_i[i].data;
                end
            end
        end
    end

    // r0 is hardwired
    assign arf_rdata_o = (arf_raddr_i == '0) ? '0 : arf[arf_raddr_i];

    //////////////////////////////////////////////////////////////////////
    // registered commit output and flush
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_q[0].valid <= 1'b0;
            commit_q[1].valid <= 1'b0;
            flush_q           <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                commit_q[i].valid <= retire[i];
                commit_q[i].areg  <= head_i[i].areg;
                commit_q[i].w_reg <= head_i[i].w_reg;
                commit_q[i].pc    <= head_i[i].pc;
                commit_q[i].data  <= head_i[i].data;
                commit_q[i].exc   <= head_i[i].exc;
            end
            // an excepting entry empties the buffer
            flush_q <= |(retire & {head_i[1].exc, head_i[0].exc});
        end
    end

    assign commit_o = commit_q;
    assign flush_o  = flush_q;

endmodule

// ==== hw/rob_core_top.sv ====
`timescale 1ns/1ns

module rob_core_top (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,

    input  rob_pkg::dispatch_req_t [1:0] dispatch_i,
    output logic                         dispatch_ready_o,
    output rob_pkg::rob_id_t [1:0]       dispatch_id_o,

    input  rob_pkg::cdb_t [1:0]          cdb_i,

    output rob_pkg::commit_t [1:0]       commit_o,
    input  logic                         commit_ready_i,
    output logic                         flush_o,

    input  rob_pkg::areg_t               arf_raddr_i,
    output rob_pkg::word_t               arf_rdata_o
);

    logic                           stage_flush;
    logic [1:0]                     commit_cnt;
    logic [1:0]                     commit_req;
    logic [1:0]                     alloc_we;
    rob_pkg::rob_id_t [1:0]         alloc_id;
    rob_pkg::rob_inst_entry_t [1:0] alloc_entry;
    rob_pkg::rob_head_t [1:0]       head;

    // exception flush or an external one
    assign stage_flush = flush_o | flush_i;

    rob_alloc u_alloc (
        .clk, .rst_n_i,
        .flush_i          (stage_flush),
        .dispatch_i, .commit_cnt_i (commit_cnt),
        .dispatch_ready_o, .dispatch_id_o,
        .alloc_we_o       (alloc_we),
        .alloc_id_o       (alloc_id),
        .alloc_entry_o    (alloc_entry)
    );

    rob u_rob (
        .clk, .rst_n_i,
        .flush_i          (stage_flush),
        .alloc_we_i       (alloc_we),
        .alloc_id_i       (alloc_id),
        .alloc_entry_i    (alloc_entry),
        .cdb_i,
        .commit_req_i     (commit_req),
        .head_o           (head),
        .commit_cnt_o     (commit_cnt)
    );

    rob_commit u_commit (
        .clk, .rst_n_i,
        .head_i           (head),
        .commit_ready_i,
        .commit_req_o     (commit_req),
        .commit_o, .flush_o,
        .arf_raddr_i, .arf_rdata_o
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released just after an edge, like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n_o = 1'b1;
    end

endmodule

// ==== test/tb_rob_core.sv ====
`timescale 1ns/1ns

module tb_rob_core;

    localparam int DRIVE_DELAY = 2;
    localparam int LEN_FILL    = 64;
    localparam int LEN_RANDOM  = 400;
    localparam int LEN_READY   = 400;
    localparam int LEN_EXC     = 500;
    localparam int LEN_FLUSH   = 300;
    localparam int LEN_DRAIN   = 300;
    localparam int LEN_ARF     = 32;
    // every phase at its longest, reset and the flush cycles included
    localparam int TOTAL_CYCLES = 4 + LEN_FILL + LEN_RANDOM + LEN_READY + LEN_EXC
                                + LEN_FLUSH + 2 + 3 * LEN_DRAIN + 4 * LEN_ARF;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 4 * 20;

    logic                         clk;
    logic                         rst_n;
    logic                         flush_in;
    rob_pkg::dispatch_req_t [1:0] dispatch;
    logic                         dispatch_ready;
    rob_pkg::rob_id_t [1:0]       dispatch_id;
    rob_pkg::cdb_t [1:0]          cdb;
    rob_pkg::commit_t [1:0]       commit;
    logic                         commit_ready;
    logic                         flush_out;
    rob_pkg::areg_t               arf_raddr;
    rob_pkg::word_t               arf_rdata;

    //////////////////////////////////////////////////////////////////////
    // reference model, one record per live entry, oldest first
    //////////////////////////////////////////////////////////////////////
    rob_pkg::rob_id_t live [$];
    rob_pkg::areg_t   m_areg [rob_pkg::ROB_DEPTH];
    logic             m_wreg [rob_pkg::ROB_DEPTH];
    rob_pkg::word_t   m_pc   [rob_pkg::ROB_DEPTH];
    rob_pkg::word_t   m_data [rob_pkg::ROB_DEPTH];
    logic             m_exc  [rob_pkg::ROB_DEPTH];
    logic             m_wb   [rob_pkg::ROB_DEPTH];
    rob_pkg::word_t   m_arf  [32];
    rob_pkg::rob_id_t exp_ptr;
    logic [1:0]       exp_retire;
    logic             flush_next;

    logic [31:0] lcg_state;
    logic [31:0] pc_next;
    int          n_checks;
    int          n_errors;
    int          accepted;
    int          retired;
    int          flush_seen;
    int          ready_low_seen;
    int          err_mark;

    tb_clock u_clock (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    rob_core_top dut (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush_in),
        .dispatch_i       (dispatch),
        .dispatch_ready_o (dispatch_ready),
        .dispatch_id_o    (dispatch_id),
        .cdb_i            (cdb),
        .commit_o         (commit),
        .commit_ready_i   (commit_ready),
        .flush_o          (flush_out),
        .arf_raddr_i      (arf_raddr),
        .arf_rdata_o      (arf_rdata)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // low LCG bits are weak, so draw from the upper ones
    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % 32'(n));
    endfunction

    function automatic logic chance(input int pct);
        return rand_below(100) < pct;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic note_error(input string msg);
        n_errors++;
        $display("error: %s", msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // one clock: check what the edge did, predict and drive the next one
    //////////////////////////////////////////////////////////////////////
    task automatic run_cycle(input int disp_pct, input int ready_pct, input int wb_pct,
                             input int exc_pct, input bit ext_flush);
        rob_pkg::rob_id_t id;
        logic             exp_flush;
        logic             ready_now;
        int               window;
        int               start;
        int               pos;
        @(posedge clk);
        #(DRIVE_DELAY);
        if (flush_next) begin
            live.delete();
            exp_ptr = '0;
        end
        exp_flush = 1'b0;
        for (int s = 0; s < 2; s++) begin
            compare_value($sformatf("commit_o[%0d].valid", s), 32'(commit[s].valid),
                          32'(exp_retire[s]));
            if (commit[s].valid) begin
                retired++;
            end
            if (exp_retire[s]) begin
                id = live.pop_front();
                compare_value("commit_o.areg", 32'(commit[s].areg), 32'(m_areg[id]));
                compare_value("commit_o.w_reg", 32'(commit[s].w_reg), 32'(m_wreg[id]));
                compare_value("commit_o.pc", commit[s].pc, m_pc[id]);
                compare_value("commit_o.data", commit[s].data, m_data[id]);
                compare_value("commit_o.exc", 32'(commit[s].exc), 32'(m_exc[id]));
                if (m_exc[id]) begin
                    exp_flush = 1'b1;
                end else if (m_wreg[id]) begin
                    m_arf[m_areg[id]] = m_data[id];
                end
            end
        end
        if (commit[1].valid && !commit[0].valid) begin
            note_error("commit slot 1 retired without slot 0");
        end
        compare_value("flush_o", 32'(flush_out), 32'(exp_flush));
        if (exp_flush) begin
            flush_seen++;
        end
        compare_value("dispatch_ready_o", 32'(dispatch_ready),
                      32'(live.size() <= rob_pkg::ROB_DEPTH - 2));
        compare_value("dispatch_id_o[0]", 32'(dispatch_id[0]), 32'(exp_ptr));
        id = exp_ptr + 1'b1;
        compare_value("dispatch_id_o[1]", 32'(dispatch_id[1]), 32'(id));
        if (!dispatch_ready) begin
            ready_low_seen++;
        end

        // the coming edge clears everything on either flush
        flush_next = exp_flush | ext_flush;
        ready_now  = !ext_flush && chance(ready_pct);
        exp_retire = 2'b00;
        if (ready_now && !exp_flush && live.size() > 0 && m_wb[live[0]]) begin
            exp_retire[0] = 1'b1;
            if (live.size() > 1 && m_wb[live[1]] && !m_exc[live[0]]) begin
                exp_retire[1] = 1'b1;
            end
        end
        commit_ready = ready_now;
        flush_in     = ext_flush;

        // write-back in random order among the 16 oldest
        cdb = '0;
        for (int b = 0; b < 2; b++) begin
            if (!flush_next && live.size() > 0 && chance(wb_pct)) begin
                window = (live.size() < 16) ? live.size() : 16;
                start  = rand_below(window);
                for (int k = 0; k < window; k++) begin
                    pos = (start + k) % window;
                    if (!m_wb[live[pos]] && !cdb[b].valid) begin
                        id            = live[pos];
                        m_wb[id]      = 1'b1;
                        m_data[id]    = lcg_next();
                        m_exc[id]     = chance(exc_pct);
                        cdb[b].valid  = 1'b1;
                        cdb[b].rob_id = id;
                        cdb[b].data   = m_data[id];
                        cdb[b].exc    = m_exc[id];
                    end
                end
            end
        end

        dispatch = '0;
        if (chance(disp_pct)) begin
            for (int s = 0; s < 2; s++) begin
                dispatch[s].valid = (s == 0) || chance(70);
                if (dispatch[s].valid) begin
                    dispatch[s].areg  = 5'(rand_below(32));
                    dispatch[s].w_reg = chance(75);
                    dispatch[s].pc    = pc_next;
                    pc_next           = pc_next + 32'd4;
                end
            end
            // refused when full, thrown away when a flush lands
            if (dispatch_ready && !flush_next) begin
                for (int s = 0; s < 2; s++) begin
                    if (dispatch[s].valid) begin
                        m_areg[exp_ptr] = dispatch[s].areg;
                        m_wreg[exp_ptr] = dispatch[s].w_reg;
                        m_pc[exp_ptr]   = dispatch[s].pc;
                        m_data[exp_ptr] = '0;
                        m_exc[exp_ptr]  = 1'b0;
                        m_wb[exp_ptr]   = 1'b0;
                        live.push_back(exp_ptr);
                        exp_ptr = exp_ptr + 1'b1;
                        accepted++;
                    end
                end
            end
        end
    endtask

    task automatic drain_buffer();
        int n;
        n = 0;
        while ((live.size() > 0 || exp_retire != 2'b00 || flush_next) && n < LEN_DRAIN) begin
            run_cycle(0, 100, 100, 0, 1'b0);
            n++;
        end
        if (n >= LEN_DRAIN) begin
            note_error("reorder buffer did not drain in time");
        end
    endtask

    // only called with the buffer empty and nothing being driven
    task automatic verify_arf();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            arf_raddr = 5'(r);
            #1;
            compare_value($sformatf("arf_rdata_o[r%0d]", r), arf_rdata,
                          (r == 0) ? 32'h0 : m_arf[5'(r)]);
        end
    endtask

    task automatic close_test(input string name);
        if (n_errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - err_mark);
        end
        err_mark = n_errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run hung");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        flush_in     = 1'b0;
        dispatch     = '0;
        cdb          = '0;
        commit_ready = 1'b0;
        arf_raddr    = '0;
        lcg_state    = 32'h8e53;
        pc_next      = 32'h0000_1000;
        exp_ptr      = '0;
        exp_retire   = 2'b00;
        flush_next   = 1'b0;
        for (int r = 0; r < 32; r++) begin
            m_arf[r] = '0;
        end
        wait (rst_n == 1'b1);

        ready_low_seen = 0;
        for (int i = 0; i < LEN_FILL; i++) begin
            run_cycle(100, 0, 50, 0, 1'b0);
        end
        if (ready_low_seen == 0) begin
            note_error("dispatch_ready_o never fell with the buffer full");
        end
        close_test("indices and back-pressure");

        for (int i = 0; i < LEN_RANDOM; i++) begin
            run_cycle(50, 100, 60, 0, 1'b0);
        end
        close_test("in-order retirement");

        for (int i = 0; i < LEN_READY; i++) begin
            run_cycle(50, 60, 60, 0, 1'b0);
        end
        close_test("dual retirement with ready drops");

        drain_buffer();
        compare_value("retired count", 32'(retired), 32'(accepted));
        verify_arf();
        close_test("architectural state");

        flush_seen = 0;
        for (int i = 0; i < LEN_EXC; i++) begin
            run_cycle(50, 90, 60, 3, 1'b0);
        end
        drain_buffer();
        if (flush_seen == 0) begin
            note_error("no exception flush happened");
        end
        verify_arf();
        close_test("exception flush");

        for (int i = 0; i < LEN_FLUSH / 2; i++) begin
            run_cycle(60, 80, 50, 0, 1'b0);
        end
        run_cycle(60, 80, 50, 0, 1'b1);
        run_cycle(0, 0, 0, 0, 1'b0);
        verify_arf();
        for (int i = 0; i < LEN_FLUSH / 2; i++) begin
            run_cycle(60, 80, 50, 0, 1'b0);
        end
        drain_buffer();
        verify_arf();
        close_test("external flush");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hw/rob_pkg.sv
hw/rob_bank_ram.sv
hw/rob_alloc.sv
hw/rob.sv
hw/rob_commit.sv
hw/rob_core_top.sv
test/tb_clock.sv
test/tb_rob_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_rob_core -Mdir obj_dir -o tb_rob_core \
    > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/tb_rob_core > "$SIM_LOG" 2>&1 \
    || { echo "build or simulation error, see $BUILD_LOG and $SIM_LOG"; exit 1; }

grep -qx "PASS: all tests" "$SIM_LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed, see $SIM_LOG"; exit 1; }
